// File: hdl/fdc_host_port.sv
module fdc_host_port (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic               rd,
	input  logic               wr,
	input  fdc_pkg::reg_addr_t addr,
	input  logic [7:0]         din,
	input  logic               busy,
	input  logic               drq,
	input  logic               idle,
	input  logic               seek_err,
	input  logic               wr_fault,
	input  logic               lost_data,
	input  logic               head_loaded,
	input  logic               track0,
	input  logic               ready,
	input  logic               intrq_set,
	input  logic               track_load,
	input  logic [7:0]         track_value,
	input  logic               sector_inc,
	input  logic               reading_buffer,
	input  logic [7:0]         buff_din,
	output logic [7:0]         dout,
	output logic [7:0]         cmd,
	output logic               cmd_start,
	output logic               force_int,
	output logic               data_taken,
	output logic [7:0]         track_reg,
	output logic [7:0]         sector_reg,
	output logic [7:0]         data_reg,
	output logic               intrq,
	output logic               buff_read
);

	logic               rd_d;
	logic               wr_d;
	logic               rd_rise;
	logic               rd_fall;
	logic               wr_rise;
	fdc_pkg::reg_addr_t cur_addr; // address of the current bus cycle
	logic               pending;  // command waiting for the sequencer
	logic               cmd_mode; // 0 after type I, 1 otherwise
	logic [7:0]         status;

	assign rd_rise = rd & ~rd_d;
	assign rd_fall = ~rd & rd_d;
	assign wr_rise = wr & ~wr_d;

	assign cmd_start = pending & idle;
	assign buff_read = reading_buffer && (addr == fdc_pkg::A_DATA);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rd_d       <= 1'b0;
			wr_d       <= 1'b0;
			cur_addr   <= fdc_pkg::A_CMD_STATUS;
			pending    <= 1'b0;
			cmd_mode   <= 1'b0;
			intrq      <= 1'b0;
			force_int  <= 1'b0;
			data_taken <= 1'b0;
			track_reg  <= 8'd0;
			sector_reg <= 8'd0;
			data_reg   <= 8'd0;
		end else begin
			rd_d       <= rd;
			wr_d       <= wr;
			force_int  <= 1'b0;
			data_taken <= 1'b0;

			if (rd_rise || wr_rise)
				cur_addr <= addr;

			if (cmd_start) begin
				pending  <= 1'b0;
				cmd_mode <= cmd[7];
			end

			if (track_load)
				track_reg <= track_value;
			if (sector_inc)
				sector_reg <= sector_reg + 8'd1; // multi-sector read

			if (rd_fall && cur_addr == fdc_pkg::A_CMD_STATUS)
				intrq <= 1'b0;
			if (rd_fall && cur_addr == fdc_pkg::A_DATA)
				data_taken <= 1'b1;

			if (wr_rise) begin
				case (addr)
					fdc_pkg::A_CMD_STATUS: begin
						intrq <= 1'b0;
						if (fdc_pkg::fdc_op_t'(din[7:4]) == fdc_pkg::OP_FORCE_INT) begin
							force_int <= 1'b1;
							cmd_mode  <= 1'b0;
							pending   <= 1'b0;
						end else if (!pending || cmd_start) begin
							cmd     <= din;
							pending <= 1'b1;
						end
					end
					fdc_pkg::A_TRACK:  if (!busy) track_reg <= din;
					fdc_pkg::A_SECTOR: if (!busy) sector_reg <= din;
					fdc_pkg::A_DATA:   data_reg <= din;
				endcase
			end

			if (intrq_set)
				intrq <= 1'b1; // end of command wins over a clear
		end
	end

	// bit 6 is write protect, always set since the image is read-only
	always_comb begin
		if (!cmd_mode)
			status = {~ready, 1'b1, head_loaded, seek_err | ~ready,
				1'b0, track0, 1'b0, busy | pending};
		else
			status = {~ready, 1'b1, wr_fault, seek_err | ~ready,
				1'b0, lost_data, drq, busy | pending};
	end

	always_comb begin
		case (addr)
			fdc_pkg::A_CMD_STATUS: dout = status;
			fdc_pkg::A_TRACK:      dout = track_reg;
			fdc_pkg::A_SECTOR:     dout = sector_reg;
			default:               dout = reading_buffer ? buff_din : data_reg;
		endcase
	end

endmodule

// File: hdl/fdc_pkg.sv
package fdc_pkg;

	//////////////////////////////////////////////////
	// host bus
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		A_CMD_STATUS = 2'd0, // command on write, status on read
		A_TRACK      = 2'd1,
		A_SECTOR     = 2'd2,
		A_DATA       = 2'd3
	} reg_addr_t;

	// upper nibble of the command byte
	typedef enum logic [3:0] {
		OP_RESTORE     = 4'h0,
		OP_SEEK        = 4'h1,
		OP_STEP        = 4'h2,
		OP_STEP_U      = 4'h3,
		OP_STEP_IN     = 4'h4,
		OP_STEP_IN_U   = 4'h5,
		OP_STEP_OUT    = 4'h6,
		OP_STEP_OUT_U  = 4'h7,
		OP_READ        = 4'h8,
		OP_READ_M      = 4'h9,
		OP_WRITE       = 4'hA,
		OP_WRITE_M     = 4'hB,
		OP_READ_ADDR   = 4'hC,
		OP_FORCE_INT   = 4'hD,
		OP_READ_TRACK  = 4'hE,
		OP_WRITE_TRACK = 4'hF
	} fdc_op_t;

	typedef enum logic [3:0] {
		READY,
		SEARCH,
		SECT_SETUP,
		READ_ARM,
		READ_DELAY,
		READ_WAIT,
		DELAY,
		ABORT,
		END_CMD
	} seq_state_t;

	//////////////////////////////////////////////////
	// geometry and timing
	//////////////////////////////////////////////////

	localparam int BUFF_AW           = 20;   // 1 MB image buffer
	localparam int SECT_LEN_W        = 11;   // up to 1024 bytes
	localparam int CMD_DELAY_CYCLES  = 4000;
	localparam int BYTE_DELAY_CYCLES = 16;
	localparam int WATCHDOG_CYCLES   = 4096;
	localparam int SEARCH_CYCLES     = 1024;

	// one timer serves delay, search and byte spacing, the longest sets the width
	localparam int TIMER_W = $clog2(CMD_DELAY_CYCLES + 1);
	localparam int WDOG_W  = $clog2(WATCHDOG_CYCLES + 1);

	typedef logic [BUFF_AW-1:0]    buff_addr_t;
	typedef logic [SECT_LEN_W-1:0] sect_len_t;
	typedef logic [TIMER_W-1:0]    timer_t;
	typedef logic [WDOG_W-1:0]     wdog_t;

endpackage

// File: hdl/fdc_sequencer.sv
module fdc_sequencer (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic [7:0]          cmd,
	input  logic                cmd_start,
	input  logic                force_int,
	input  logic                data_taken,
	input  logic                ready,
	input  logic [7:0]          data_reg,
	input  fdc_pkg::buff_addr_t sector_base,
	input  fdc_pkg::sect_len_t  sector_len,
	input  logic                sector_valid,
	output logic [7:0]          disk_track,
	output fdc_pkg::sect_len_t  byte_addr,
	output logic                busy,
	output logic                drq,
	output logic                idle,
	output logic                seek_err,
	output logic                wr_fault,
	output logic                lost_data,
	output logic                head_loaded,
	output logic                track0,
	output logic                intrq_set,
	output logic                track_load,
	output logic [7:0]          track_value,
	output logic                sector_inc,
	output logic                reading_buffer
);

	fdc_pkg::seq_state_t       state;
	fdc_pkg::fdc_op_t          op;
	fdc_pkg::timer_t           timer;
	fdc_pkg::wdog_t            wdog;
	fdc_pkg::sect_len_t        remaining;  // bytes left in the sector
	logic                      step_out;   // last step direction
	logic                      multi;
	logic [7:0]                next_track;
	logic                      wdog_bark;

	assign op = fdc_pkg::fdc_op_t'(cmd[7:4]);

	// step-in/out carry the direction in bit 5, plain step reuses it
	assign next_track = (cmd[6] ? cmd[5] : step_out) ? disk_track - 8'd1 : disk_track + 8'd1;

	assign wdog_bark = (wdog == '0);
	assign idle      = (state == fdc_pkg::READY);
	assign track0    = (disk_track == 8'd0);
	assign intrq_set = (state == fdc_pkg::END_CMD); // same edge busy drops

	//////////////////////////////////////////////////
	// lost-data watchdog
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			wdog <= '0;
		else if (state == fdc_pkg::READ_DELAY && timer == '0)
			wdog <= fdc_pkg::wdog_t'(fdc_pkg::WATCHDOG_CYCLES); // armed with drq
		else if (!wdog_bark)
			wdog <= wdog - 1'b1;
	end

	//////////////////////////////////////////////////
	// command FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state          <= fdc_pkg::READY;
			timer          <= '0;
			busy           <= 1'b0;
			drq            <= 1'b0;
			seek_err       <= 1'b0;
			wr_fault       <= 1'b0;
			lost_data      <= 1'b0;
			head_loaded    <= 1'b0;
			reading_buffer <= 1'b0;
			track_load     <= 1'b0;
			sector_inc     <= 1'b0;
			step_out       <= 1'b0;
			multi          <= 1'b0;
			disk_track     <= 8'd0;
		end else begin
			track_load <= 1'b0;
			sector_inc <= 1'b0;

			case (state)
				fdc_pkg::READY: if (cmd_start) begin
					busy  <= 1'b1;
					timer <= fdc_pkg::timer_t'(fdc_pkg::CMD_DELAY_CYCLES);
					state <= fdc_pkg::DELAY;
					case (op)
						fdc_pkg::OP_RESTORE: begin
							head_loaded <= cmd[3];
							disk_track  <= 8'd0;
							track_value <= 8'd0;
							track_load  <= 1'b1;
						end
						fdc_pkg::OP_SEEK: begin
							head_loaded <= cmd[3];
							disk_track  <= data_reg;
						end
						fdc_pkg::OP_STEP, fdc_pkg::OP_STEP_U,
						fdc_pkg::OP_STEP_IN, fdc_pkg::OP_STEP_IN_U,
						fdc_pkg::OP_STEP_OUT, fdc_pkg::OP_STEP_OUT_U: begin
							if (cmd[6])
								step_out <= cmd[5];
							head_loaded <= cmd[3];
							disk_track  <= next_track;
							track_value <= next_track;
							track_load  <= cmd[4]; // update flag
						end
						fdc_pkg::OP_READ, fdc_pkg::OP_READ_M: begin
							{seek_err, wr_fault, lost_data} <= 3'b000;
							reading_buffer <= 1'b1;
							multi          <= cmd[4];
							timer          <= fdc_pkg::timer_t'(fdc_pkg::SEARCH_CYCLES);
							state          <= fdc_pkg::SEARCH;
						end
						fdc_pkg::OP_WRITE, fdc_pkg::OP_WRITE_M: begin
							{seek_err, lost_data} <= 2'b00;
							wr_fault <= 1'b1; // image is read-only
						end
						default: begin
							// read address and the track commands
							{wr_fault, lost_data} <= 2'b00;
							seek_err <= 1'b1;
						end
					endcase
				end

				fdc_pkg::SEARCH: begin
					if (!ready) begin
						seek_err <= 1'b1;
						state    <= fdc_pkg::END_CMD;
					end else if (timer != '0) begin
						timer <= timer - 1'b1;
					end else if (!sector_valid) begin
						seek_err <= 1'b1; // record not found
						state    <= fdc_pkg::END_CMD;
					end else begin
						state <= fdc_pkg::SECT_SETUP;
					end
				end

				fdc_pkg::SECT_SETUP: begin
					byte_addr <= '0;
					remaining <= sector_len;
					state     <= fdc_pkg::READ_ARM;
				end

				fdc_pkg::READ_ARM: begin
					// arm and count edges add up to the byte delay
					timer <= fdc_pkg::timer_t'(fdc_pkg::BYTE_DELAY_CYCLES - 2);
					state <= fdc_pkg::READ_DELAY;
				end

				fdc_pkg::READ_DELAY: begin
					if (timer != '0) begin
						timer <= timer - 1'b1;
					end else begin
						drq   <= 1'b1;
						state <= fdc_pkg::READ_WAIT;
					end
				end

				fdc_pkg::READ_WAIT: if (data_taken || wdog_bark) begin
					drq <= 1'b0;
					if (!data_taken)
						lost_data <= 1'b1; // byte skipped
					if (remaining == fdc_pkg::sect_len_t'(1)) begin
						if (multi) begin
							sector_inc <= 1'b1;
							timer      <= fdc_pkg::timer_t'(fdc_pkg::SEARCH_CYCLES);
							state      <= fdc_pkg::SEARCH;
						end else begin
							state <= fdc_pkg::END_CMD;
						end
					end else begin
						byte_addr <= byte_addr + 1'b1;
						remaining <= remaining - 1'b1;
						state     <= fdc_pkg::READ_ARM;
					end
				end

				fdc_pkg::DELAY: begin
					if (timer != '0)
						timer <= timer - 1'b1;
					else
						state <= fdc_pkg::END_CMD;
				end

				fdc_pkg::ABORT: begin
					drq            <= 1'b0;
					reading_buffer <= 1'b0;
					state          <= fdc_pkg::END_CMD;
				end

				fdc_pkg::END_CMD: begin
					busy           <= 1'b0;
					drq            <= 1'b0;
					reading_buffer <= 1'b0;
					state          <= fdc_pkg::READY;
				end

				default: state <= fdc_pkg::READY;
			endcase

			// force interrupt overrides whatever is running
			if (force_int) begin
				if (!idle && state != fdc_pkg::END_CMD)
					state <= fdc_pkg::ABORT;
				else if (idle && !cmd_start)
					{seek_err, wr_fault, lost_data} <= 3'b000;
			end
		end
	end

endmodule

// File: hdl/fdc_top.sv
module fdc_top (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic                rd,
	input  logic                wr,
	input  fdc_pkg::reg_addr_t  addr,
	input  logic [7:0]          din,
	output logic [7:0]          dout,
	output logic                drq,
	output logic                intrq,
	output logic                busy,
	input  logic                ready,
	input  logic [2:0]          size_code,
	input  logic                side,
	output fdc_pkg::buff_addr_t buff_addr,
	output logic                buff_read,
	input  logic [7:0]          buff_din
);

	logic [7:0]          cmd;
	logic                cmd_start;
	logic                force_int;
	logic                data_taken;
	logic [7:0]          sector_reg;
	logic [7:0]          data_reg;
	logic                idle;
	logic                seek_err;
	logic                wr_fault;
	logic                lost_data;
	logic                head_loaded;
	logic                track0;
	logic                intrq_set;
	logic                track_load;
	logic [7:0]          track_value;
	logic                sector_inc;
	logic                reading_buffer;
	logic [7:0]          disk_track;
	fdc_pkg::sect_len_t  byte_addr;
	fdc_pkg::buff_addr_t sector_base;
	fdc_pkg::sect_len_t  sector_len;
	logic                sector_valid;

	assign buff_addr = sector_base + fdc_pkg::buff_addr_t'(byte_addr);

	fdc_host_port host_port_inst (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.rd             (rd),
		.wr             (wr),
		.addr           (addr),
		.din            (din),
		.busy           (busy),
		.drq            (drq),
		.idle           (idle),
		.seek_err       (seek_err),
		.wr_fault       (wr_fault),
		.lost_data      (lost_data),
		.head_loaded    (head_loaded),
		.track0         (track0),
		.ready          (ready),
		.intrq_set      (intrq_set),
		.track_load     (track_load),
		.track_value    (track_value),
		.sector_inc     (sector_inc),
		.reading_buffer (reading_buffer),
		.buff_din       (buff_din),
		.dout           (dout),
		.cmd            (cmd),
		.cmd_start      (cmd_start),
		.force_int      (force_int),
		.data_taken     (data_taken),
		.track_reg      (),           // host side only
		.sector_reg     (sector_reg),
		.data_reg       (data_reg),
		.intrq          (intrq),
		.buff_read      (buff_read)
	);

	fdc_track_map track_map_inst (
		.size_code         (size_code),
		.disk_track        (disk_track),
		.side              (side),
		.sector_reg        (sector_reg),
		.sector_base       (sector_base),
		.sectors_per_track (),         // folded into sector_valid
		.sector_len        (sector_len),
		.sector_valid      (sector_valid)
	);

	fdc_sequencer sequencer_inst (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.cmd            (cmd),
		.cmd_start      (cmd_start),
		.force_int      (force_int),
		.data_taken     (data_taken),
		.ready          (ready),
		.data_reg       (data_reg),
		.sector_base    (sector_base),
		.sector_len     (sector_len),
		.sector_valid   (sector_valid),
		.disk_track     (disk_track),
		.byte_addr      (byte_addr),
		.busy           (busy),
		.drq            (drq),
		.idle           (idle),
		.seek_err       (seek_err),
		.wr_fault       (wr_fault),
		.lost_data      (lost_data),
		.head_loaded    (head_loaded),
		.track0         (track0),
		.intrq_set      (intrq_set),
		.track_load     (track_load),
		.track_value    (track_value),
		.sector_inc     (sector_inc),
		.reading_buffer (reading_buffer)
	);

endmodule

// File: hdl/fdc_track_map.sv
module fdc_track_map (
	input  logic [2:0]          size_code,
	input  logic [7:0]          disk_track,
	input  logic                side,
	input  logic [7:0]          sector_reg,
	output fdc_pkg::buff_addr_t sector_base,
	output logic [7:0]          sectors_per_track,
	output fdc_pkg::sect_len_t  sector_len,
	output logic                sector_valid
);

	logic [1:0]          len_code;   // sector size is 128 << len_code
	fdc_pkg::buff_addr_t track_side; // tracks are stored side by side
	fdc_pkg::buff_addr_t sect_index;

	// the five fixed layouts
	always_comb begin
		case (size_code)
			3'd0: begin
				sectors_per_track = 8'd26;
				len_code          = 2'd0;
			end
			3'd1: begin
				sectors_per_track = 8'd16;
				len_code          = 2'd1;
			end
			3'd2: begin
				sectors_per_track = 8'd9;
				len_code          = 2'd2;
			end
			3'd3: begin
				sectors_per_track = 8'd5;
				len_code          = 2'd3;
			end
			3'd4: begin
				sectors_per_track = 8'd10;
				len_code          = 2'd2;
			end
			default: begin
				sectors_per_track = 8'd0; // no sector is valid
				len_code          = 2'd0;
			end
		endcase
	end

	assign track_side = fdc_pkg::buff_addr_t'({disk_track, side});

	// sectors are numbered from 1
	assign sect_index = track_side * fdc_pkg::buff_addr_t'(sectors_per_track)
		+ fdc_pkg::buff_addr_t'(sector_reg) - 1'b1;

	assign sector_base = sect_index << (7 + len_code);
	assign sector_len  = fdc_pkg::sect_len_t'(128) << len_code;

	assign sector_valid = (sector_reg != 8'd0) && (sector_reg <= sectors_per_track);

endmodule

// File: list.f
hdl/fdc_pkg.sv
hdl/fdc_host_port.sv
hdl/fdc_track_map.sv
hdl/fdc_sequencer.sv
hdl/fdc_top.sv
tests/fdc_properties.sv
tests/fdc_checker.sv
tests/fdc_tb.sv

// File: tests/fdc_checker.sv
module fdc_checker (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic [7:0]          dout,
	input  logic                drq,
	input  logic                intrq,
	input  logic                busy,
	input  logic                check_req,    // compare dout on this edge
	input  logic                check_sector, // expected byte comes from the image rule
	input  logic [7:0]          exp_data,
	input  logic [7:0]          exp_mask,
	input  fdc_pkg::buff_addr_t exp_addr,
	input  logic                end_req,      // tb saw intrq
	input  logic                no_drq,       // command must not offer data
	output int                  error_count,
	output int                  check_count
);
	timeunit 1ns;
	timeprecision 1ns;

	logic [7:0] expected;
	logic       intrq_d;
	logic       busy_seen; // since the last end of command
	logic       drq_seen;

	// image content is the low address byte xor address bits 15:8
	function automatic logic [7:0] image_byte(input fdc_pkg::buff_addr_t a);
		return a[7:0] ^ a[15:8];
	endfunction

	always_comb begin
		if (check_sector)
			expected = image_byte(exp_addr);
		else
			expected = exp_data;
	end

	always_ff @(posedge clk_sys) begin : compare
		int new_errors;
		int new_checks;
		new_errors = 0;
		new_checks = 0;
		if (!rst_n) begin
			error_count <= 0;
			check_count <= 0;
			intrq_d     <= 1'b0;
			busy_seen   <= 1'b0;
			drq_seen    <= 1'b0;
		end else begin
			intrq_d <= intrq;
			if (busy)
				busy_seen <= 1'b1;
			if (drq)
				drq_seen <= 1'b1;

			if (check_req) begin
				new_checks++;
				if ((dout & exp_mask) !== (expected & exp_mask)) begin
					new_errors++;
					if (check_sector)
						$display("error dout at image byte 0x%05h: expected 0x%02h got 0x%02h",
							exp_addr, expected, dout);
					else
						$display("error dout: expected 0x%02h got 0x%02h, mask 0x%02h",
							expected, dout, exp_mask);
				end
			end

			// a command ends where intrq rises
			if (intrq && !intrq_d) begin
				new_checks++;
				if (busy) begin
					new_errors++;
					$display("error busy at intrq: expected 0x0 got 0x%0h", busy);
				end
				if (!busy_seen) begin
					new_errors++;
					$display("command ended with intrq but busy was never seen high");
				end
			end

			if (end_req) begin
				new_checks++;
				if (no_drq && drq_seen) begin
					new_errors++;
					$display("drq was raised during a command that transfers no data");
				end
				busy_seen <= 1'b0; // next command starts clean
				drq_seen  <= 1'b0;
			end

			error_count <= error_count + new_errors;
			check_count <= check_count + new_checks;
		end
	end

endmodule

// File: tests/fdc_properties.sv
module fdc_properties (
	input logic clk_sys,
	input logic rst_n,
	input logic drq,
	input logic intrq,
	input logic busy,
	input logic buff_read
);
	timeunit 1ns;
	timeprecision 1ns;

	// a byte is only offered inside a command
	drq_needs_busy: assert property (@(posedge clk_sys) disable iff (!rst_n)
		drq |-> busy)
		else $error("drq high while busy is low");

	// end of command drops busy on the same edge
	intrq_after_busy: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(intrq) |-> !busy)
		else $error("intrq rose while busy was still high");

	read_needs_busy: assert property (@(posedge clk_sys) disable iff (!rst_n)
		buff_read |-> busy)
		else $error("buffer read outside a command");

endmodule

bind fdc_top fdc_properties fdc_properties_inst (
	.clk_sys   (clk_sys),
	.rst_n     (rst_n),
	.drq       (drq),
	.intrq     (intrq),
	.busy      (busy),
	.buff_read (buff_read)
);

// File: tests/fdc_stimulus.txt
// columns: op addr data expected, hex. op 1 write, 2 read (data is mask), 3 wait intrq
// (data 1 forbids drq), 4 read sector (data is count, expected is base), 5 side and size_code
5 0 1 0
1 0 00 0     // restore
3 0 1 0
2 1 FF 00
2 0 FF 44    // track0 and read-only
1 0 50 0     // step in with update
3 0 1 0
1 0 50 0
3 0 1 0
1 0 50 0
3 0 1 0
1 0 70 0     // step out with update
3 0 1 0
2 1 FF 02
1 3 05 0     // seek to 5, track register stays
1 0 10 0
3 0 1 0
2 1 FF 02
1 3 02 0
1 0 10 0
3 0 1 0
1 2 03 0     // sector 3, size 1, track 2, side 0
1 0 80 0
4 3 100 4200
3 0 0 0
1 0 90 0     // multi-sector into sector 4
4 3 200 4200
1 0 D0 0
3 0 0 0
2 2 FF 05
1 0 80 0     // sector 5, aborted part way
4 3 10 4400
1 0 D0 0
3 0 0 0
2 0 FF 40
5 0 0 0      // size 0 has 26 sectors
1 2 1B 0
1 0 80 0
3 0 1 0
2 0 FF 50    // seek error
1 2 01 0
1 0 A0 0     // write sector
3 0 1 0
2 0 FF 60    // write fault
0 0 0 0

// File: tests/fdc_tb.sv
module fdc_tb;
	timeunit 1ns;
	timeprecision 1ns;

	logic                clk_sys;
	logic                rst_n;
	logic                rd;
	logic                wr;
	fdc_pkg::reg_addr_t  addr;
	logic [7:0]          din;
	logic [7:0]          dout;
	logic                drq;
	logic                intrq;
	logic                busy;
	logic                ready;
	logic [2:0]          size_code;
	logic                side;
	fdc_pkg::buff_addr_t buff_addr;
	logic                buff_read;
	logic [7:0]          buff_din;
	logic                check_req;
	logic                check_sector;
	logic [7:0]          exp_data;
	logic [7:0]          exp_mask;
	fdc_pkg::buff_addr_t exp_addr;
	logic                end_req;
	logic                no_drq;
	int                  error_count;
	int                  check_count;
	int                  cycles;
	int                  cycle_limit;
	int                  bad_lines;
	logic [19:0]         stim [0:255]; // four words per line

	fdc_top fdc_top_inst (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.rd        (rd),
		.wr        (wr),
		.addr      (addr),
		.din       (din),
		.dout      (dout),
		.drq       (drq),
		.intrq     (intrq),
		.busy      (busy),
		.ready     (ready),
		.size_code (size_code),
		.side      (side),
		.buff_addr (buff_addr),
		.buff_read (buff_read),
		.buff_din  (buff_din)
	);

	fdc_checker fdc_checker_inst (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.dout         (dout),
		.drq          (drq),
		.intrq        (intrq),
		.busy         (busy),
		.check_req    (check_req),
		.check_sector (check_sector),
		.exp_data     (exp_data),
		.exp_mask     (exp_mask),
		.exp_addr     (exp_addr),
		.end_req      (end_req),
		.no_drq       (no_drq),
		.error_count  (error_count),
		.check_count  (check_count)
	);

	//////////////////////////////////////////////////
	// clock, image RAM, timeout
	//////////////////////////////////////////////////

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		if (buff_read)
			buff_din <= buff_addr[7:0] ^ buff_addr[15:8]; // one cycle latency
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: run stopped after %0d cycles", cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	function automatic bit line_present(input int k);
		return k < 256 && !$isunknown(stim[k]) && stim[k] != 20'h0;
	endfunction

	// worst case per line, doubled
	function automatic int cycle_budget();
		int total;
		int k;
		total = 0;
		k     = 0;
		while (line_present(k)) begin
			total += fdc_pkg::CMD_DELAY_CYCLES + fdc_pkg::SEARCH_CYCLES;
			if (stim[k] == 20'h4)
				total += int'(stim[k+2]) * (fdc_pkg::BYTE_DELAY_CYCLES + 8);
			k += 4;
		end
		return 2 * total;
	endfunction

	//////////////////////////////////////////////////
	// bus operations
	//////////////////////////////////////////////////

	task automatic bus_write(input logic [1:0] a, input logic [7:0] d);
		@(posedge clk_sys);
		addr <= fdc_pkg::reg_addr_t'(a);
		din  <= d;
		wr   <= 1'b1;
		@(posedge clk_sys);
		wr <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic bus_read(input logic [1:0] a, input logic sector_byte,
		input logic [7:0] mask, input logic [7:0] value, input fdc_pkg::buff_addr_t image_addr);
		@(posedge clk_sys);
		addr <= fdc_pkg::reg_addr_t'(a);
		rd   <= 1'b1;
		@(posedge clk_sys);
		check_req    <= 1'b1; // checker samples on the next edge
		check_sector <= sector_byte;
		exp_mask     <= mask;
		exp_data     <= value;
		exp_addr     <= image_addr;
		@(posedge clk_sys);
		check_req <= 1'b0;
		rd        <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic wait_intrq(input logic forbid_drq);
		do @(negedge clk_sys); while (!intrq);
		@(posedge clk_sys);
		end_req <= 1'b1;
		no_drq  <= forbid_drq;
		@(posedge clk_sys);
		end_req <= 1'b0;
	endtask

	task automatic read_sector(input int count, input fdc_pkg::buff_addr_t base);
		for (int n = 0; n < count; n++) begin
			do @(negedge clk_sys); while (!drq);
			bus_read(2'd3, 1'b1, 8'hFF, 8'h00, base + fdc_pkg::buff_addr_t'(n));
			while (drq)
				@(negedge clk_sys); // byte accepted
		end
	endtask

	task automatic run_line(input int k);
		logic [3:0]  op;
		logic [1:0]  a;
		logic [19:0] d;
		logic [19:0] e;
		op = stim[k][3:0];
		a  = stim[k+1][1:0];
		d  = stim[k+2];
		e  = stim[k+3];
		case (op)
			4'h1: bus_write(a, d[7:0]);
			4'h2: bus_read(a, 1'b0, d[7:0], e[7:0], '0); // data column is the mask
			4'h3: wait_intrq(d[0]);
			4'h4: read_sector(int'(d), e);
			4'h5: begin
				@(posedge clk_sys);
				side      <= a[0];
				size_code <= d[2:0];
			end
			default: begin
				$display("stimulus line %0d has an unknown operation %0h", k / 4 + 1, op);
				bad_lines++;
			end
		endcase
	endtask

	initial begin : main_seq
		int line_pos;
		rst_n        = 1'b0;
		rd           = 1'b0;
		wr           = 1'b0;
		addr         = fdc_pkg::A_CMD_STATUS;
		din          = 8'h00;
		ready        = 1'b1; // disk always present
		size_code    = 3'd1;
		side         = 1'b0;
		buff_din     = 8'h00;
		check_req    = 1'b0;
		check_sector = 1'b0;
		exp_data     = 8'h00;
		exp_mask     = 8'h00;
		exp_addr     = '0;
		end_req      = 1'b0;
		no_drq       = 1'b0;
		bad_lines    = 0;
		$readmemh("tests/fdc_stimulus.txt", stim);
		cycle_limit = cycle_budget();
		repeat (2) @(posedge clk_sys);
		rst_n <= 1'b1;
		line_pos = 0;
		while (line_present(line_pos)) begin
			run_line(line_pos);
			line_pos += 4;
		end
		repeat (4) @(posedge clk_sys);
		if (check_count == 0) begin
			$display("no checks were run, the stimulus file is missing or empty");
			bad_lines++;
		end
		$display("closing: %0d checker errors, %0d bad stimulus lines, %0d checks",
			error_count, bad_lines, check_count);
		if (error_count == 0 && bad_lines == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule
